//--- dv/dro_tb.sv
`timescale 1ns/1ps

module dro_tb
	import dro_cfg_pkg::*;
();

	localparam int MAX_CYCLES = 20000;                             // Well above the whole run

	logic              clk = 1'b0;
	logic              rst;
	logic              wb_cyc, wb_stb, wb_we, wb_ack;
	logic [2:0]        wb_adr;
	logic [31:0]       wb_dat_w, wb_dat_r;
	logic [NUM_CH-1:0] dro_clk, dro_do;
	logic [31:0]       systime, rpt_data;
	logic              rpt_valid, rpt_last, rpt_ready;
	logic              ready_random;
	int                cycles = 0;
	logic [31:0]       words [$];
	logic              lasts [$];

	dro_top dro_top_inst (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		#2;
		systime   <= systime + 1;
		rpt_ready <= ready_random ? 1'($urandom % 2) : 1'b1;   // Random stalls in the last test
	end

	// ----------------------------------------
	// Checking
	// ----------------------------------------
	task automatic report_mismatch(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout, no activity");
			$display("sim failed");
			$fatal(1, "run did not finish");
		end
	end

	assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else report_mismatch("wb_ack longer than one cycle");
	assert property (@(posedge clk) disable iff (rst) rpt_last |-> rpt_valid)
		else report_mismatch("rpt_last without rpt_valid");
	assert property (@(posedge clk) disable iff (rst)
		(rpt_valid && !rpt_ready) |=> (rpt_valid && $stable(rpt_data) && $stable(rpt_last)))
		else report_mismatch("report word changed while stalled");

	always @(negedge clk) begin
		if (!rst && rpt_valid && rpt_ready) begin                   // One transfer per cycle
			words.push_back(rpt_data);
			lasts.push_back(rpt_last);
		end
	end

	// ----------------------------------------
	// Bus and scale models
	// ----------------------------------------
	task automatic wb_cycle(input logic we, input int adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		@(posedge clk);
		#2;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = 3'(adr);
		wb_dat_w = wdat;
		@(negedge clk);
		assert (!wb_ack) else report_mismatch("wb_ack before strobe was sampled");
		@(negedge clk);
		assert (wb_ack) else report_mismatch("wb_ack missing one cycle after strobe");
		rdat = wb_dat_r;
		@(posedge clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	// Drives n bits MSB first and returns the systime of the first falling scl
	task automatic drive_frame(input int ch, input logic [31:0] data, input int n,
			input bit glitch, output logic [31:0] t0);
		for (int i = n - 1; i >= 0; i--) begin
			@(posedge clk);
			if (i == n - 1)
				t0 = systime + 1;
			#2;
			dro_clk[ch] = 1'b0;
			dro_do[ch]  = data[i];
			if (glitch && i == 0) begin
				repeat (3) @(posedge clk);
				#2 dro_clk[ch] = 1'b1;                         // One-cycle spike while low
				@(posedge clk);
				#2 dro_clk[ch] = 1'b0;
				repeat (3) @(posedge clk);
			end else begin
				repeat (7) @(posedge clk);
			end
			#2 dro_clk[ch] = 1'b1;
			repeat (7) @(posedge clk);
		end
	endtask

	task automatic expect_report(input int ch, input logic [31:0] data, input int n,
			input logic [31:0] t0);
		logic [31:0] hdr;
		int          waited;
		hdr    = {8'd48, 8'(ch), 10'd0, 6'(n)};
		waited = 0;
		while (words.size() < 3 && waited < 400) begin
			@(posedge clk);
			waited++;
		end
		assert (words.size() >= 3)
			else report_mismatch($sformatf("no report from ch %0d", ch));
		assert (words[0] == hdr)
			else report_mismatch($sformatf("header %h, expected %h", words[0], hdr));
		assert (words[1] == data)
			else report_mismatch($sformatf("data %h, expected %h", words[1], data));
		assert (words[2] >= t0 && words[2] <= t0 + 2 + DEBOUNCE_CYCLES + 2)
			else report_mismatch($sformatf("start_time %0d, first fall at %0d", words[2], t0));
		assert (!lasts[0] && !lasts[1] && lasts[2])
			else report_mismatch("rpt_last not on the third word only");
		repeat (3) begin
			void'(words.pop_front());
			void'(lasts.pop_front());
		end
	endtask

	task automatic expect_silence();
		repeat (150) @(posedge clk);
		assert (words.size() == 0)
			else report_mismatch($sformatf("%0d unexpected report words", words.size()));
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		int          n;
		logic [31:0] d0, d3, rd, val, t0, t3;
		void'($urandom(56));
		rst          = 1'b1;
		{wb_cyc, wb_stb, wb_we} = '0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		dro_clk      = '1;                                         // Scales idle with clock high
		dro_do       = '0;
		systime      = '0;
		rpt_ready    = 1'b1;
		ready_random = 1'b0;
		repeat (4) @(posedge clk);
		#2 rst = 1'b0;
		repeat (10) @(posedge clk);

		for (int ch = 0; ch < NUM_CH; ch++) begin
			for (int r = 0; r < 2; r++) begin
				val = $urandom;
				wb_cycle(1'b1, 2 * ch + r, val, rd);
				wb_cycle(1'b0, 2 * ch + r, '0, rd);
				val = val & (r == 0 ? 32'((1 << TIMEOUT_BITS) - 1) : 32'h1);
				assert (rd == val)
					else report_mismatch($sformatf("reg %0d read %h, expected %h",
						2 * ch + r, rd, val));
				wb_cycle(1'b1, 2 * ch + r, '0, rd);
			end
		end

		n  = 1 + $urandom % 32;
		d0 = $urandom;
		if (n < 32)
			d0 = d0 & ((32'd1 << n) - 1);
		wb_cycle(1'b1, 4, 40, rd);
		drive_frame(2, d0, n, 1'b0, t0);
		expect_report(2, d0, n, t0);
		drive_frame(2, d0, n, 1'b0, t0);                           // Same frame is filtered
		expect_silence();
		wb_cycle(1'b1, 5, 1, rd);
		drive_frame(2, d0, n, 1'b0, t0);
		expect_report(2, d0, n, t0);

		drive_frame(1, d0, n, 1'b0, t0);                           // Channel 1 stays disabled
		expect_silence();
		drive_frame(2, d0, n, 1'b1, t0);
		expect_report(2, d0, n, t0);

		n  = 1 + $urandom % 32;
		d0 = $urandom >> (32 - n);
		d3 = $urandom >> (32 - n);
		wb_cycle(1'b1, 0, 40, rd);
		wb_cycle(1'b1, 6, 40, rd);
		ready_random = 1'b1;
		fork
			drive_frame(0, d0, n, 1'b0, t0);
			drive_frame(3, d3, n, 1'b0, t3);
		join
		expect_report(0, d0, n, t0);
		expect_report(3, d3, n, t3);
		ready_random = 1'b0;
		expect_silence();

		$display("sim passed");
		$finish;
	end

endmodule

//--- verilog.f
verilog/dro_cfg_pkg.sv
verilog/dro_report_pkg.sv
verilog/dro_frame_if.sv
verilog/dro_wb_regs.sv
verilog/dro_channel.sv
verilog/dro_report_collector.sv
verilog/dro_top.sv
dv/dro_tb.sv

//--- verilog/dro_cfg_pkg.sv
package dro_cfg_pkg;

	// ----------------------------------------
	// Channels and input conditioning
	// ----------------------------------------
	localparam int NUM_CH          = 4;
	localparam int CH_BITS         = 2;
	localparam int DEBOUNCE_CYCLES = 3;                            // Cycles a new level must hold
	localparam int DEB_BITS        = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int TIMEOUT_BITS    = 16;                           // Zero disables the channel

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	// Address bits [2:1] pick the channel, bit 0 picks the register of its pair
	localparam int   WB_ADR_BITS        = 3;
	localparam logic REG_TIMEOUT        = 1'b0;
	localparam logic REG_MODE           = 1'b1;
	localparam int   MODE_ALWAYS_REPORT = 0;                       // Bit of the mode register

	// ----------------------------------------
	// Channel frame FSM
	// ----------------------------------------
	localparam logic [1:0] DR_IDLE    = 2'd0;
	localparam logic [1:0] DR_CLK_LO  = 2'd1;
	localparam logic [1:0] DR_CLK_HI  = 2'd2;
	localparam logic [1:0] DR_WAIT_HI = 2'd3;                     // Frame broken, wait for idle

endpackage

//--- verilog/dro_channel.sv
`timescale 1ns/1ps

module dro_channel
	import dro_cfg_pkg::*;
	import dro_report_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    scl,
	input  logic                    sda,
	input  logic [31:0]             systime,
	input  logic [TIMEOUT_BITS-1:0] timeout,
	input  logic                    always_report,
	dro_frame_if.rx                 frame
);

	// Bit 0 carries the scale clock, bit 1 the data line
	logic [1:0]              meta;
	logic [1:0]              sync;
	logic [1:0]              deb;
	logic [DEB_BITS-1:0]     deb_cnt [2];
	logic                    deb_clk;
	logic                    deb_dat;

	logic [1:0]              state;
	logic [TIMEOUT_BITS-1:0] tmo_cnt;
	logic [31:0]             shift;
	logic [FRAME_BITS_W-1:0] bit_cnt;
	logic [31:0]             t_start;
	logic [31:0]             prev_data;
	logic [FRAME_BITS_W-1:0] prev_bits;
	logic                    enabled;
	logic                    expired;
	logic                    pending;
	logic                    changed;

	// ----------------------------------------
	// Synchroniser and debouncers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			meta    <= '0;
			sync    <= '0;
			deb     <= '0;
			deb_cnt <= '{default: '0};
		end else begin
			meta <= {sda, scl};
			sync <= meta;
			for (int i = 0; i < 2; i++) begin
				if (sync[i] == deb[i]) begin
					deb_cnt[i] <= '0;                          // Glitch over, start again
				end else if (deb_cnt[i] == DEB_BITS'(DEBOUNCE_CYCLES - 1)) begin
					deb[i]     <= sync[i];
					deb_cnt[i] <= '0;
				end else begin
					deb_cnt[i] <= deb_cnt[i] + 1'b1;
				end
			end
		end
	end

	assign deb_clk = deb[0];
	assign deb_dat = deb[1];

	assign enabled = timeout != '0;
	assign expired = tmo_cnt == TIMEOUT_BITS'(1);
	assign pending = frame.valid && !frame.ack;                    // Unreported frame still held
	assign changed = (shift != prev_data) || (bit_cnt != prev_bits);

	// ----------------------------------------
	// Frame FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= DR_IDLE;
			tmo_cnt     <= '0;
			frame.valid <= 1'b0;
			prev_data   <= '1;                                     // First frame always differs
			prev_bits   <= '0;
		end else begin
			if (tmo_cnt != '0)
				tmo_cnt <= tmo_cnt - 1'b1;
			if (frame.ack)
				frame.valid <= 1'b0;
			if (!enabled) begin
				state   <= DR_IDLE;
				tmo_cnt <= '0;
			end else begin
				case (state)
					DR_IDLE: begin
						if (!deb_clk) begin
							t_start <= systime;
							shift   <= '0;
							bit_cnt <= '0;
							tmo_cnt <= timeout;
							state   <= DR_CLK_LO;
						end
					end
					DR_CLK_LO: begin
						if (deb_clk) begin
							shift   <= {shift[30:0], deb_dat};
							tmo_cnt <= timeout;
							state   <= DR_CLK_HI;
							if (bit_cnt != '1)
								bit_cnt <= bit_cnt + 1'b1;
						end else if (expired) begin
							state <= DR_WAIT_HI;               // Clock stuck low, drop it
						end
					end
					DR_CLK_HI: begin
						if (!deb_clk) begin
							tmo_cnt <= timeout;
							state   <= DR_CLK_LO;
						end else if (expired) begin
							state <= DR_IDLE;
							if (!pending) begin
								prev_data <= shift;
								prev_bits <= bit_cnt;
								if (changed || always_report) begin
									frame.valid      <= 1'b1;
									frame.data       <= shift;
									frame.bits       <= bit_cnt;
									frame.start_time <= t_start;
								end
							end
						end
					end
					default: begin
						if (deb_clk)
							state <= DR_IDLE;
					end
				endcase
			end
		end
	end

endmodule

//--- verilog/dro_frame_if.sv
`timescale 1ns/1ps

interface dro_frame_if
	import dro_report_pkg::*;
();

	logic                    valid;
	logic                    ack;                                  // One-cycle pulse
	logic [31:0]             data;
	logic [FRAME_BITS_W-1:0] bits;
	logic [31:0]             start_time;

	// Payload holds still while valid is high
	modport rx (
		output valid,
		output data,
		output bits,
		output start_time,
		input  ack
	);

	modport tx (
		input  valid,
		input  data,
		input  bits,
		input  start_time,
		output ack
	);

endinterface

//--- verilog/dro_report_collector.sv
`timescale 1ns/1ps

module dro_report_collector
	import dro_cfg_pkg::*;
	import dro_report_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	dro_frame_if.tx     frames [NUM_CH],
	output logic [31:0] rpt_data,
	output logic        rpt_valid,
	output logic        rpt_last,
	input  logic        rpt_ready
);

	logic [NUM_CH-1:0]       valid_vec;
	logic [31:0]             data_arr [NUM_CH];
	logic [31:0]             time_arr [NUM_CH];
	logic [FRAME_BITS_W-1:0] bits_arr [NUM_CH];
	logic [1:0]              state;
	logic [CH_BITS-1:0]      sel;
	logic [CH_BITS-1:0]      pick;
	logic                    xfer;
	rpt_word_u               hdr;

	assign rpt_valid = state != COL_SCAN;
	assign rpt_last  = state == COL_TIME;
	assign xfer      = rpt_valid && rpt_ready;

	// Per-channel frame signals gathered into plain arrays
	for (genvar i = 0; i < NUM_CH; i++) begin : g_frame
		assign valid_vec[i]   = frames[i].valid;
		assign data_arr[i]    = frames[i].data;
		assign time_arr[i]    = frames[i].start_time;
		assign bits_arr[i]    = frames[i].bits;
		assign frames[i].ack  = rpt_last && xfer && (sel == CH_BITS'(i));
	end

	// Lowest channel number wins
	always_comb begin
		pick = '0;
		for (int i = NUM_CH - 1; i >= 0; i--) begin
			if (valid_vec[i])
				pick = CH_BITS'(i);
		end
	end

	always_comb begin
		hdr.hdr.rtype    = RPT_TYPE_DRO;
		hdr.hdr.channel  = 8'(pick);
		hdr.hdr.reserved = '0;
		hdr.hdr.nbits    = bits_arr[pick];
	end

	// ----------------------------------------
	// Three-word report sequencer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= COL_SCAN;
			sel   <= '0;
		end else begin
			case (state)
				COL_SCAN: begin
					if (|valid_vec) begin
						sel      <= pick;
						rpt_data <= hdr.raw;
						state    <= COL_HDR;
					end
				end
				COL_HDR: begin
					if (rpt_ready) begin
						rpt_data <= data_arr[sel];
						state    <= COL_DATA;
					end
				end
				COL_DATA: begin
					if (rpt_ready) begin
						rpt_data <= time_arr[sel];
						state    <= COL_TIME;
					end
				end
				default: begin
					if (rpt_ready)
						state <= COL_SCAN;                     // Channel sees its ack now
				end
			endcase
		end
	end

endmodule

//--- verilog/dro_report_pkg.sv
package dro_report_pkg;

	localparam logic [7:0] RPT_TYPE_DRO = 8'd48;
	localparam int         FRAME_BITS_W = 6;                       // Saturates beyond its range

	// ----------------------------------------
	// Report words
	// ----------------------------------------
	typedef struct packed {
		logic [7:0]              rtype;
		logic [7:0]              channel;
		logic [9:0]              reserved;
		logic [FRAME_BITS_W-1:0] nbits;
	} rpt_header_t;

	// First word of a report is a header, the other two are raw payload
	typedef union packed {
		rpt_header_t hdr;
		logic [31:0] raw;
	} rpt_word_u;

	// ----------------------------------------
	// Collector FSM
	// ----------------------------------------
	localparam logic [1:0] COL_SCAN = 2'd0;
	localparam logic [1:0] COL_HDR  = 2'd1;
	localparam logic [1:0] COL_DATA = 2'd2;
	localparam logic [1:0] COL_TIME = 2'd3;                       // Last word of the report

endpackage

//--- verilog/dro_top.sv
`timescale 1ns/1ps

module dro_top
	import dro_cfg_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [WB_ADR_BITS-1:0] wb_adr,
	input  logic [31:0]            wb_dat_w,
	output logic [31:0]            wb_dat_r,
	output logic                   wb_ack,
	input  logic [NUM_CH-1:0]      dro_clk,
	input  logic [NUM_CH-1:0]      dro_do,
	input  logic [31:0]            systime,
	output logic [31:0]            rpt_data,
	output logic                   rpt_valid,
	output logic                   rpt_last,
	input  logic                   rpt_ready
);

	logic [NUM_CH-1:0][TIMEOUT_BITS-1:0] timeout;
	logic [NUM_CH-1:0]                   always_report;

	dro_frame_if frame_bus [NUM_CH] ();

	dro_wb_regs regs_inst (
		.clk           (clk),
		.rst           (rst),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.timeout       (timeout),
		.always_report (always_report)
	);

	// One receiver per scale
	for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
		dro_channel channel_inst (
			.clk           (clk),
			.rst           (rst),
			.scl           (dro_clk[g]),
			.sda           (dro_do[g]),
			.systime       (systime),
			.timeout       (timeout[g]),
			.always_report (always_report[g]),
			.frame         (frame_bus[g])
		);
	end

	dro_report_collector collector_inst (
		.clk       (clk),
		.rst       (rst),
		.frames    (frame_bus),
		.rpt_data  (rpt_data),
		.rpt_valid (rpt_valid),
		.rpt_last  (rpt_last),
		.rpt_ready (rpt_ready)
	);

endmodule

//--- verilog/dro_wb_regs.sv
`timescale 1ns/1ps

module dro_wb_regs
	import dro_cfg_pkg::*;
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic [WB_ADR_BITS-1:0]              wb_adr,
	input  logic [31:0]                         wb_dat_w,
	output logic [31:0]                         wb_dat_r,
	output logic                                wb_ack,
	output logic [NUM_CH-1:0][TIMEOUT_BITS-1:0] timeout,
	output logic [NUM_CH-1:0]                   always_report
);

	logic [CH_BITS-1:0] ch;
	logic               reg_sel;
	logic               req;

	assign ch      = wb_adr[WB_ADR_BITS-1:1];
	assign reg_sel = wb_adr[0];
	assign req     = wb_cyc && wb_stb && !wb_ack;                 // Ack low for a cycle in between

	// ----------------------------------------
	// Ack and register writes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack        <= 1'b0;
			timeout       <= '0;
			always_report <= '0;
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin
				case (reg_sel)
					REG_TIMEOUT: begin
						timeout[ch] <= wb_dat_w[TIMEOUT_BITS-1:0];
					end
					REG_MODE: begin
						always_report[ch] <= wb_dat_w[MODE_ALWAYS_REPORT];
					end
				endcase
			end
		end
	end

	// Read data lands together with the ack
	always_ff @(posedge clk) begin
		if (req) begin
			case (reg_sel)
				REG_TIMEOUT: begin
					wb_dat_r <= 32'(timeout[ch]);
				end
				REG_MODE: begin
					wb_dat_r                     <= '0;
					wb_dat_r[MODE_ALWAYS_REPORT] <= always_report[ch];
				end
			endcase
		end
	end

endmodule
